// ==== Makefile ====
# Verilator simulation of the dual-port TCB memory

LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, pass or fail from $(LOG)"
	@echo "make clean  remove the build directory and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tcb_mem_tb
	./obj_dir/Vtcb_mem_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== list.f ====
+incdir+.
tcb_pkg.sv
tcb_if.sv
tcb_mem_port.sv
tcb_mem_bank.sv
tcb_mem.sv
tcb_mem_props.sv
tcb_mem_tb.sv

// ==== tcb_if.sv ====
////////////////////////////////////////////////////////////////////////////
// TCB bus interface and the per-lane bank access interface
////////////////////////////////////////////////////////////////////////////

`include "tcb_params.svh"

// TCB bus, clock and reset come from the enclosing module
interface tcb_if (
  input logic clk,
  input logic reset
);

  // request
  logic                 vld;
  logic                 wen;
  logic [`TCB_AW-1:0]   adr;
  // log2 of transfer size, reference mode
  logic [2-1:0]         siz;
  // byte enables, byte-enable mode
  logic [`TCB_BEW-1:0]  ben;
  logic [`TCB_DW-1:0]   wdt;
  // response, valid TCB_DLY cycles after the transfer
  logic [`TCB_DW-1:0]   rdt;

  modport man (
    input  clk, reset,
    output vld, wen, adr, siz, ben, wdt,
    input  rdt
  );

  modport sub (
    input  clk, reset,
    input  vld, wen, adr, siz, ben, wdt,
    output rdt
  );

endinterface

// one row access per byte lane, between a port adapter and the banks
interface tcb_lane_if;

  tcb_pkg::tcb_lane_req_t req [`TCB_BEW];
  tcb_pkg::tcb_lane_rsp_t rsp [`TCB_BEW];

  modport port (output req, input  rsp);
  modport bank (input  req, output rsp);

endinterface

// ==== tcb_mem.sv ====
////////////////////////////////////////////////////////////////////////////
// dual-port TCB memory top: reference port 0, byte-enable port 1
////////////////////////////////////////////////////////////////////////////

`include "tcb_params.svh"

module tcb_mem (
  input  logic                tcb,
  input  logic                reset,
  // port 0, reference mode
  input  logic                p0_vld,
  input  logic                p0_wen,
  input  logic [`TCB_AW-1:0]  p0_adr,
  input  logic [2-1:0]        p0_siz,
  input  logic [`TCB_DW-1:0]  p0_wdt,
  output logic [`TCB_DW-1:0]  p0_rdt,
  // port 1, byte-enable mode
  input  logic                p1_vld,
  input  logic                p1_wen,
  input  logic [`TCB_AW-1:0]  p1_adr,
  input  logic [`TCB_BEW-1:0] p1_ben,
  input  logic [`TCB_DW-1:0]  p1_wdt,
  output logic [`TCB_DW-1:0]  p1_rdt
);

  ////////////////////////////////////////////////////////////////////////////
  // bus bundles
  ////////////////////////////////////////////////////////////////////////////

  tcb_if tcb_p0 (.clk(tcb), .reset(reset));
  tcb_if tcb_p1 (.clk(tcb), .reset(reset));

  // port 0 has no byte enables
  assign tcb_p0.vld = p0_vld;
  assign tcb_p0.wen = p0_wen;
  assign tcb_p0.adr = p0_adr;
  assign tcb_p0.siz = p0_siz;
  assign tcb_p0.ben = '0;
  assign tcb_p0.wdt = p0_wdt;
  assign p0_rdt     = tcb_p0.rdt;

  // port 1 has no size
  assign tcb_p1.vld = p1_vld;
  assign tcb_p1.wen = p1_wen;
  assign tcb_p1.adr = p1_adr;
  assign tcb_p1.siz = '0;
  assign tcb_p1.ben = p1_ben;
  assign tcb_p1.wdt = p1_wdt;
  assign p1_rdt     = tcb_p1.rdt;

  // lane requests per port
  tcb_lane_if lane_p0 ();
  tcb_lane_if lane_p1 ();

  ////////////////////////////////////////////////////////////////////////////
  // port adapters and storage
  ////////////////////////////////////////////////////////////////////////////

  tcb_mem_port #(
    .MODE (tcb_pkg::TCB_REFERENCE)
  ) port_0_i (
    .tcb  (tcb_p0.sub),
    .lane (lane_p0.port)
  );

  tcb_mem_port #(
    .MODE (tcb_pkg::TCB_BYTE_EN)
  ) port_1_i (
    .tcb  (tcb_p1.sub),
    .lane (lane_p1.port)
  );

  // lp0 has write priority
  tcb_mem_bank bank_i (
    .tcb   (tcb),
    .reset (reset),
    .lp0   (lane_p0.bank),
    .lp1   (lane_p1.bank)
  );

endmodule

// ==== tcb_mem_bank.sv ====
////////////////////////////////////////////////////////////////////////////
// byte-lane storage banks, two row ports per lane, port 0 write priority
////////////////////////////////////////////////////////////////////////////

`include "tcb_params.svh"

module tcb_mem_bank (
  input  logic     tcb,
  input  logic     reset,
  tcb_lane_if.bank lp0,
  tcb_lane_if.bank lp1
);

  // rows per lane
  localparam int unsigned RN = `TCB_SZ / `TCB_BEW;

  for (genvar l = 0; l < `TCB_BEW; l++) begin : g_lane

    // lane storage, one byte per row
    logic [8-1:0]           mem [RN];
    // requests of both ports, index is the port number
    tcb_pkg::tcb_lane_req_t req [2];
    // read data pipeline per port
    logic [8-1:0]           rd  [2][`TCB_DLY];

    assign req[0] = lp0.req[l];
    assign req[1] = lp1.req[l];

    // port 1 first, a port 0 write to the same row overrides it
    always_ff @(posedge tcb) begin
      if (req[1].en && req[1].wen) begin
        mem[req[1].row] <= req[1].wdt;
      end
      if (req[0].en && req[0].wen) begin
        mem[req[0].row] <= req[0].wdt;
      end
    end

    // registered read, sees the row before any write of this edge
    always_ff @(posedge tcb) begin
      if (reset) begin
        rd <= '{default: '0};
      end else begin
        for (int p = 0; p < 2; p++) begin
          if (req[p].en && !req[p].wen) begin
            rd[p][0] <= mem[req[p].row];
          end
          for (int d = 1; d < `TCB_DLY; d++) begin
            rd[p][d] <= rd[p][d-1];
          end
        end
      end
    end

    // last stage back to each port
    assign lp0.rsp[l].rdt = rd[0][`TCB_DLY-1];
    assign lp1.rsp[l].rdt = rd[1][`TCB_DLY-1];

  end

endmodule

// ==== tcb_mem_port.sv ====
////////////////////////////////////////////////////////////////////////////
// TCB port adapter: splits a transfer into byte-lane row requests
// and rebuilds the read data when the bank bytes come back
////////////////////////////////////////////////////////////////////////////

`include "tcb_params.svh"

module tcb_mem_port #(
  parameter tcb_pkg::tcb_mode_t MODE = tcb_pkg::TCB_REFERENCE
)(
  tcb_if.sub       tcb,
  tcb_lane_if.port lane
);

  // lane offset width
  localparam int unsigned OW = $clog2(`TCB_BEW);

  // byte count decoded from siz
  logic [3-1:0]         cnt;
  // active bytes, indexed by byte position in the transfer
  logic [`TCB_BEW-1:0]  bmsk;
  // active lanes, indexed by bank lane
  logic [`TCB_BEW-1:0]  lmsk;
  // read mask and offset delay line
  logic [`TCB_BEW-1:0]  msk_q [`TCB_DLY];
  logic [OW-1:0]        off_q [`TCB_DLY];
  // bank bytes after masking
  logic [8-1:0]         rsp_b [`TCB_BEW];

  // siz 3 would be wider than the bus, clip to a word
  always_comb begin
    case (tcb.siz)
      2'd0:    cnt = 3'd1;
      2'd1:    cnt = 3'd2;
      default: cnt = 3'd4;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // request side, combinational
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `TCB_BEW; i++) begin : g_lane
    // byte position served by lane i
    logic [OW-1:0]      bi;
    // its byte address, wraps with the memory
    logic [`TCB_AW-1:0] ba;
    // source byte for the write and output byte for the read
    logic [OW-1:0]      src;

    assign bmsk[i] = (MODE == tcb_pkg::TCB_REFERENCE) ? (i < cnt) : tcb.ben[i];

    assign bi = OW'(i) - tcb.adr[OW-1:0];
    assign ba = tcb.adr + `TCB_AW'(bi);

    assign lmsk[i] = tcb.vld & bmsk[bi];

    // reference mode takes byte bi, byte-enable mode keeps the lane
    assign lane.req[i] = '{
      en:  lmsk[i],
      wen: tcb.wen,
      row: ba[`TCB_AW-1:OW],
      wdt: (MODE == tcb_pkg::TCB_REFERENCE) ? tcb.wdt[8*bi +: 8] : tcb.wdt[8*i +: 8]
    };

    // lanes outside the delayed mask read as zero
    assign rsp_b[i] = msk_q[`TCB_DLY-1][i] ? lane.rsp[i].rdt : 8'h00;

    // rotate back so byte 0 lands on the lowest lane
    assign src = (MODE == tcb_pkg::TCB_REFERENCE) ? OW'(i) + off_q[`TCB_DLY-1] : OW'(i);
    assign tcb.rdt[8*i +: 8] = rsp_b[src];
  end

  ////////////////////////////////////////////////////////////////////////////
  // response side, delayed to match the bank
  ////////////////////////////////////////////////////////////////////////////

  // only reads load the mask, writes and idle cycles give zero
  always_ff @(posedge tcb.clk) begin
    if (tcb.reset) begin
      msk_q <= '{default: '0};
    end else begin
      msk_q[0] <= tcb.wen ? '0 : lmsk;
      for (int d = 1; d < `TCB_DLY; d++) begin
        msk_q[d] <= msk_q[d-1];
      end
    end
  end

  // offset only matters under a set mask
  always_ff @(posedge tcb.clk) begin
    off_q[0] <= tcb.adr[OW-1:0];
    for (int d = 1; d < `TCB_DLY; d++) begin
      off_q[d] <= off_q[d-1];
    end
  end

endmodule

// ==== tcb_mem_props.sv ====
////////////////////////////////////////////////////////////////////////////
// concurrent assertions on the TCB memory top-level ports
////////////////////////////////////////////////////////////////////////////

`include "tcb_params.svh"

module tcb_mem_props (
  input logic               tcb,
  input logic               reset,
  input logic               p0_vld,
  input logic               p0_wen,
  input logic [`TCB_DW-1:0] p0_rdt,
  input logic               p1_vld,
  input logic               p1_wen,
  input logic [`TCB_DW-1:0] p1_rdt
);

  timeunit 1ns;
  timeprecision 100ps;

  // no read in flight, rdt must be zero
  a_p0_idle: assert property (@(posedge tcb) disable iff (reset)
    !(p0_vld && !p0_wen) |=> p0_rdt == '0) else $error("p0_rdt not zero without a read");
  a_p1_idle: assert property (@(posedge tcb) disable iff (reset)
    !(p1_vld && !p1_wen) |=> p1_rdt == '0) else $error("p1_rdt not zero without a read");

  // read data fully known one cycle after a read
  a_p0_known: assert property (@(posedge tcb) disable iff (reset)
    (p0_vld && !p0_wen) |=> !$isunknown(p0_rdt)) else $error("p0_rdt has unknown bits");
  a_p1_known: assert property (@(posedge tcb) disable iff (reset)
    (p1_vld && !p1_wen) |=> !$isunknown(p1_rdt)) else $error("p1_rdt has unknown bits");

  // handshake defined outside reset
  a_p0_vld: assert property (@(posedge tcb) !reset |-> !$isunknown(p0_vld))
    else $error("p0_vld unknown");
  a_p1_vld: assert property (@(posedge tcb) !reset |-> !$isunknown(p1_vld))
    else $error("p1_vld unknown");

endmodule

// ==== tcb_mem_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the dual-port TCB memory with a directed table and a
// random phase against a byte model, plus the bound assertion module
////////////////////////////////////////////////////////////////////////////

`include "tcb_params.svh"

bind tcb_mem tcb_mem_props props_i (
  .tcb    (tcb),
  .reset  (reset),
  .p0_vld (p0_vld),
  .p0_wen (p0_wen),
  .p0_rdt (p0_rdt),
  .p1_vld (p1_vld),
  .p1_wen (p1_wen),
  .p1_rdt (p1_rdt)
);

module tcb_mem_tb;

  timeunit 1ns;
  timeprecision 100ps;

  // one directed transfer
  typedef struct packed {
    logic                port;
    logic                wen;
    logic [`TCB_AW-1:0]  adr;
    // siz for port 0 and ben for port 1
    logic [4-1:0]        sb;
    logic [`TCB_DW-1:0]  wdt;
    logic [`TCB_DW-1:0]  rdt;
    // next row shares this cycle
    logic                nxt;
  } row_t;

  localparam int NROW = 30;

  // memory is filled with fill_byte() before this table runs
  localparam row_t TBL [NROW] = '{
    '{1'b0, 1'b1, 8'h10, 4'h2, 32'h44332211, 32'h00000000, 1'b0},
    '{1'b0, 1'b0, 8'h10, 4'h2, 32'h00000000, 32'h44332211, 1'b0},
    '{1'b0, 1'b1, 8'h03, 4'h1, 32'h0000bbaa, 32'h00000000, 1'b0},
    '{1'b0, 1'b0, 8'h03, 4'h1, 32'h00000000, 32'h0000bbaa, 1'b0},
    '{1'b0, 1'b1, 8'hfe, 4'h2, 32'h87654321, 32'h00000000, 1'b0},
    '{1'b0, 1'b0, 8'hfe, 4'h2, 32'h00000000, 32'h87654321, 1'b0},
    '{1'b0, 1'b0, 8'h04, 4'h0, 32'h00000000, 32'h000000bb, 1'b0},
    '{1'b0, 1'b0, 8'h02, 4'h2, 32'h00000000, 32'ha0bbaaa7, 1'b0},
    '{1'b1, 1'b1, 8'h20, 4'h5, 32'h11223344, 32'h00000000, 1'b0},
    '{1'b1, 1'b0, 8'h20, 4'hf, 32'h00000000, 32'h86228444, 1'b0},
    '{1'b1, 1'b0, 8'h21, 4'h3, 32'h00000000, 32'h00228400, 1'b0},
    '{1'b1, 1'b0, 8'h23, 4'h3, 32'h00000000, 32'h86000081, 1'b0},
    '{1'b1, 1'b1, 8'h27, 4'h6, 32'haabbccdd, 32'h00000000, 1'b0},
    '{1'b0, 1'b0, 8'h28, 4'h1, 32'h00000000, 32'h0000ccdd, 1'b0},
    '{1'b1, 1'b0, 8'h10, 4'hf, 32'h00000000, 32'h44332211, 1'b0},
    '{1'b0, 1'b1, 8'h40, 4'h0, 32'h000000e0, 32'h00000000, 1'b1},
    '{1'b1, 1'b1, 8'h40, 4'h1, 32'h000000f1, 32'h00000000, 1'b0},
    '{1'b1, 1'b0, 8'h40, 4'h1, 32'h00000000, 32'h000000e0, 1'b0},
    '{1'b0, 1'b1, 8'h40, 4'h0, 32'h0000005a, 32'h00000000, 1'b1},
    '{1'b1, 1'b0, 8'h40, 4'h1, 32'h00000000, 32'h000000e0, 1'b0},
    '{1'b1, 1'b0, 8'h40, 4'h1, 32'h00000000, 32'h0000005a, 1'b0},
    '{1'b1, 1'b1, 8'h41, 4'h1, 32'h00007700, 32'h00000000, 1'b1},
    '{1'b0, 1'b0, 8'h41, 4'h0, 32'h00000000, 32'h000000e4, 1'b0},
    '{1'b0, 1'b0, 8'h41, 4'h0, 32'h00000000, 32'h00000077, 1'b0},
    '{1'b0, 1'b0, 8'h10, 4'h2, 32'h00000000, 32'h44332211, 1'b1},
    '{1'b1, 1'b0, 8'h20, 4'hf, 32'h00000000, 32'h86228444, 1'b0},
    '{1'b0, 1'b0, 8'hfe, 4'h2, 32'h00000000, 32'h87654321, 1'b1},
    '{1'b1, 1'b0, 8'h28, 4'h3, 32'h00000000, 32'h0000ccdd, 1'b0},
    '{1'b0, 1'b0, 8'h03, 4'h1, 32'h00000000, 32'h0000bbaa, 1'b1},
    '{1'b1, 1'b0, 8'h40, 4'h3, 32'h00000000, 32'h0000775a, 1'b0}
  };

  logic                tcb = 1'b0;
  logic                reset;
  logic                p0_vld, p0_wen, p1_vld, p1_wen;
  logic [`TCB_AW-1:0]  p0_adr, p1_adr;
  logic [2-1:0]        p0_siz;
  logic [`TCB_BEW-1:0] p1_ben;
  logic [`TCB_DW-1:0]  p0_wdt, p0_rdt, p1_wdt, p1_rdt;
  // byte model of the memory
  logic [8-1:0]        mem_m [`TCB_SZ];
  logic [32-1:0]       lfsr;

  tcb_mem dut_i (.*);

  always #10 tcb = ~tcb;

  // reset over the first 3 rising edges
  initial begin
    reset = 1'b1;
    repeat (3) @(negedge tcb);
    reset = 1'b0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // model and helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [8-1:0] fill_byte(input int a);
    return 8'(a) ^ 8'ha5;
  endfunction

  function automatic int size_bytes(input logic [2-1:0] siz);
    return (siz == 2'd0) ? 1 : (siz == 2'd1) ? 2 : 4;
  endfunction

  // byte b of rdt is the byte at adr+b
  function automatic logic [`TCB_DW-1:0] ref_read(input logic [7:0] adr, input logic [1:0] siz);
    logic [`TCB_DW-1:0] r;
    logic [`TCB_AW-1:0] a;
    r = '0;
    for (int b = 0; b < size_bytes(siz); b++) begin
      a = adr + 8'(b);
      r[8*b +: 8] = mem_m[a];
    end
    return r;
  endfunction

  // byte at adr+b sits on lane (adr+b) mod 4
  function automatic logic [`TCB_DW-1:0] ben_read(input logic [7:0] adr, input logic [3:0] ben);
    logic [`TCB_DW-1:0] r;
    logic [`TCB_AW-1:0] a;
    r = '0;
    for (int b = 0; b < `TCB_BEW; b++) begin
      a = adr + 8'(b);
      if (ben[b]) begin
        r[8*a[1:0] +: 8] = mem_m[a];
      end
    end
    return r;
  endfunction

  // port 1 first so port 0 wins a collision
  task automatic model_write();
    logic [`TCB_AW-1:0] a;
    if (p1_vld && p1_wen) begin
      for (int b = 0; b < `TCB_BEW; b++) begin
        a = p1_adr + 8'(b);
        if (p1_ben[b]) begin
          mem_m[a] = p1_wdt[8*a[1:0] +: 8];
        end
      end
    end
    if (p0_vld && p0_wen) begin
      for (int b = 0; b < size_bytes(p0_siz); b++) begin
        a = p0_adr + 8'(b);
        mem_m[a] = p0_wdt[8*b +: 8];
      end
    end
  endtask

  // Galois form with taps x^32+x^22+x^2+x+1
  function automatic logic [32-1:0] lfsr_step(input logic [32-1:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [32-1:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s = %h, expected %h", $time, name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic set_idle();
    {p0_vld, p0_wen, p0_adr, p0_siz, p0_wdt} = '0;
    {p1_vld, p1_wen, p1_adr, p1_ben, p1_wdt} = '0;
  endtask

  task automatic drive_port(input logic port, input logic wen, input logic [7:0] adr,
                            input logic [3:0] sb, input logic [31:0] wdt);
    if (port) begin
      {p1_vld, p1_wen, p1_adr, p1_ben, p1_wdt} = {1'b1, wen, adr, sb, wdt};
    end else begin
      {p0_vld, p0_wen, p0_adr, p0_siz, p0_wdt} = {1'b1, wen, adr, sb[1:0], wdt};
    end
  endtask

  // check rdt of the transfer already on the bus one cycle later
  task automatic run_cycle(input logic [31:0] e0, input logic [31:0] e1);
    model_write();
    @(negedge tcb);
    check("p0_rdt", p0_rdt, e0);
    check("p1_rdt", p1_rdt, e1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          i, ntr, wt;
    logic [31:0] v, w, a, s, d, e0, e1;
    set_idle();
    lfsr = 32'd84007;
    wt = 0;
    while (reset !== 1'b0) begin
      @(negedge tcb);
      wt++;
      if (wt > 10) begin
        $display("reset was not released within 10 cycles");
        $display("CHECKS FAILED");
        $fatal(1, "reset timeout");
      end
    end
    // whole-memory fill through port 0
    for (int k = 0; k < `TCB_SZ; k += 4) begin
      set_idle();
      drive_port(1'b0, 1'b1, 8'(k), 4'h2,
                 {fill_byte(k+3), fill_byte(k+2), fill_byte(k+1), fill_byte(k)});
      run_cycle('0, '0);
    end
    // directed rows
    i = 0;
    while (i < NROW) begin
      set_idle();
      e0 = '0;
      e1 = '0;
      do begin
        drive_port(TBL[i].port, TBL[i].wen, TBL[i].adr, TBL[i].sb, TBL[i].wdt);
        if (TBL[i].port) begin
          e1 = TBL[i].rdt;
        end else begin
          e0 = TBL[i].rdt;
        end
        i++;
      end while (TBL[i-1].nxt);
      run_cycle(e0, e1);
    end
    // random mix on both ports
    ntr = 0;
    while (ntr < 400) begin
      set_idle();
      for (int p = 0; p < 2; p++) begin
        take_bits(1, v);
        if (v[0] && ntr < 400) begin
          take_bits(1, w);
          take_bits(8, a);
          take_bits((p == 0) ? 2 : 4, s);
          // no siz 3 on the bus
          if (p == 0 && s[1:0] == 2'd3) begin
            s = 32'd2;
          end
          take_bits(32, d);
          drive_port(p[0], w[0], a[7:0], s[3:0], d);
          ntr++;
        end
      end
      e0 = (p0_vld && !p0_wen) ? ref_read(p0_adr, p0_siz) : '0;
      e1 = (p1_vld && !p1_wen) ? ben_read(p1_adr, p1_ben) : '0;
      run_cycle(e0, e1);
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== tcb_params.svh ====
////////////////////////////////////////////////////////////////////////////
// memory geometry and bus widths for the TCB dual-port memory
////////////////////////////////////////////////////////////////////////////

`ifndef TCB_PARAMS_SVH
`define TCB_PARAMS_SVH

// byte address width
`define TCB_AW  8
// data width and bytes per word
`define TCB_DW  32
`define TCB_BEW 4
// memory size in bytes
`define TCB_SZ  256
// row address width inside one byte-lane bank
`define TCB_ROW 6
// read latency in cycles
`define TCB_DLY 1

`endif

// ==== tcb_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared types: port mode, per-lane request and response
////////////////////////////////////////////////////////////////////////////

`include "tcb_params.svh"

package tcb_pkg;

  // how a port interprets its request
  typedef enum logic {
    // adr + siz, bytes in byte order starting at lane 0
    TCB_REFERENCE,
    // adr + ben, each byte on its own lane
    TCB_BYTE_EN
  } tcb_mode_t;

  ////////////////////////////////////////////////////////////////////////////
  // lane side
  ////////////////////////////////////////////////////////////////////////////

  // one byte-lane row access
  typedef struct packed {
    logic                en;
    logic                wen;
    logic [`TCB_ROW-1:0] row;
    logic [8-1:0]        wdt;
  } tcb_lane_req_t;

  // registered read byte from one lane
  typedef struct packed {
    logic [8-1:0] rdt;
  } tcb_lane_rsp_t;

endpackage
